// File: source/tilemap_pkg.sv
package tilemap_pkg;

	//////////////////////////////////////////////////
	// Address map and sizes
	//////////////////////////////////////////////////

	localparam int ram_addr_w = 14;
	localparam int tile_addr_w = 13;
	localparam int tile_ram_depth = 8192;

	localparam logic [ram_addr_w-1:0] layer_a_base = 14'h0000;
	localparam logic [ram_addr_w-1:0] layer_b_base = 14'h1000;
	localparam logic [ram_addr_w-1:0] reg_base = 14'h2000;

	// Offsets within one layer's register group, B group sits 4 above A
	localparam logic [1:0] reg_scroll_x_lo = 2'd0;
	localparam logic [1:0] reg_scroll_x_hi = 2'd1;
	localparam logic [1:0] reg_scroll_y = 2'd2;

	//////////////////////////////////////////////////
	// Slot schedule within one 8-pixel group
	//////////////////////////////////////////////////

	localparam logic [2:0] slot_a_attr = 3'd0;
	localparam logic [2:0] slot_a_code = 3'd1;
	localparam logic [2:0] slot_b_attr = 3'd2;
	localparam logic [2:0] slot_b_code = 3'd3;
	localparam logic [2:0] slot_cpu_first = 3'd4;
	localparam logic [2:0] slot_cpu_last = 3'd6;
	localparam logic [2:0] slot_valid = 3'd5;

	// Map size in tiles
	localparam int map_cols = 64;
	localparam int map_rows = 32;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ram_addr_w-1:0] adr;
		logic [7:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [7:0] dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic [8:0] scroll_x;
		logic [7:0] scroll_y;
	} scroll_t;

	typedef struct packed {
		logic in_sync;
		logic [2:0] slot;
		logic [5:0] group;
		logic [7:0] line;
	} beam_t;

	typedef struct packed {
		logic en;
		logic we;
		logic [tile_addr_w-1:0] addr;
		logic [7:0] wdata;
	} ram_req_t;

	// Same 16-bit tile word, as stored and as decoded
	typedef union packed {
		struct packed {
			logic [7:0] attr;
			logic [7:0] code;
		} bytes;
		struct packed {
			logic [4:0] color;
			logic [2:0] code_hi;
			logic [7:0] code_lo;
		} fields;
	} tile_entry_u;

	typedef struct packed {
		logic [13:0] gfx_addr;
		logic [4:0] color;
		logic [2:0] fine_x;
	} tile_fetch_t;

endpackage

// File: source/tile_ram.sv
`timescale 1ns/1ps

module tile_ram (
	input logic CLK_6M,
	input tilemap_pkg::ram_req_t req,
	output logic [7:0] rdata
);

	logic [7:0] mem [tilemap_pkg::tile_ram_depth];

	// Read first, a write returns the old byte
	always_ff @(posedge CLK_6M) begin
		if (req.en) begin
			if (req.we)
				mem[req.addr] <= req.wdata;
			rdata <= mem[req.addr];
		end
	end

endmodule

// File: source/tile_ram_arbiter.sv
`timescale 1ns/1ps

module tile_ram_arbiter (
	input logic CLK_6M,
	input logic rst_n,
	input tilemap_pkg::beam_t beam,
	input logic [tilemap_pkg::tile_addr_w-1:0] addr_a,
	input logic [tilemap_pkg::tile_addr_w-1:0] addr_b,
	input tilemap_pkg::ram_req_t cpu_req,
	output logic cpu_done,
	output logic [7:0] cpu_rdata,
	output logic [7:0] ram_rdata
);

	tilemap_pkg::ram_req_t ram_req;
	logic cpu_slot;
	logic layer_slot;
	logic grant;
	logic [tilemap_pkg::tile_addr_w-1:0] layer_addr;

	//////////////////////////////////////////////////
	// Slot schedule
	//////////////////////////////////////////////////

	// CPU owns slots 4 to 6 and all of sync, slot 7 stays idle
	assign cpu_slot = beam.in_sync ||
		(beam.slot >= tilemap_pkg::slot_cpu_first && beam.slot <= tilemap_pkg::slot_cpu_last);
	assign layer_slot = !beam.in_sync && (beam.slot <= tilemap_pkg::slot_b_code);

	// Done blocks a second grant while the port still holds en
	assign grant = cpu_slot && cpu_req.en && !cpu_done;

	always_comb begin
		case (beam.slot)
			tilemap_pkg::slot_a_attr: layer_addr = addr_a;
			tilemap_pkg::slot_a_code: layer_addr = addr_a + 13'd1;
			tilemap_pkg::slot_b_attr: layer_addr = addr_b;
			tilemap_pkg::slot_b_code: layer_addr = addr_b + 13'd1;
			default: layer_addr = addr_a;
		endcase
	end

	always_comb begin
		ram_req = '0;
		if (grant) begin
			ram_req = cpu_req;
		end else if (layer_slot) begin
			ram_req.en = 1'b1;
			ram_req.addr = layer_addr;
		end
	end

	// Read data is out one cycle after the grant
	always_ff @(posedge CLK_6M or negedge rst_n) begin
		if (!rst_n)
			cpu_done <= 1'b0;
		else
			cpu_done <= grant;
	end

	tile_ram u_tile_ram (
		.CLK_6M(CLK_6M),
		.req(ram_req),
		.rdata(ram_rdata)
	);

	assign cpu_rdata = ram_rdata;

endmodule

// File: source/wb_cpu_port.sv
`timescale 1ns/1ps

module wb_cpu_port (
	input logic CLK_6M,
	input logic rst_n,
	input tilemap_pkg::wb_req_t wb_req,
	input logic cpu_done,
	input logic [7:0] cpu_rdata,
	output tilemap_pkg::wb_rsp_t wb_rsp,
	output tilemap_pkg::ram_req_t cpu_req,
	output tilemap_pkg::scroll_t scroll_a,
	output tilemap_pkg::scroll_t scroll_b
);

	logic access;
	logic is_ram;
	logic reg_hit;
	logic [2:0] reg_off;
	logic ram_start;
	logic reg_start;
	logic reg_write;
	logic ram_busy;
	logic ack_q;
	logic [7:0] rdata_q;
	logic [7:0] reg_rdata;

	function automatic tilemap_pkg::scroll_t write_scroll(input tilemap_pkg::scroll_t cur,
			input logic [1:0] off, input logic [7:0] d);
		tilemap_pkg::scroll_t nxt;
		nxt = cur;
		case (off)
			tilemap_pkg::reg_scroll_x_lo: nxt.scroll_x[7:0] = d;
			tilemap_pkg::reg_scroll_x_hi: nxt.scroll_x[8] = d[0];
			tilemap_pkg::reg_scroll_y: nxt.scroll_y = d;
			default: ;
		endcase
		return nxt;
	endfunction

	function automatic logic [7:0] read_scroll(input tilemap_pkg::scroll_t s,
			input logic [1:0] off);
		case (off)
			tilemap_pkg::reg_scroll_x_lo: return s.scroll_x[7:0];
			tilemap_pkg::reg_scroll_x_hi: return {7'd0, s.scroll_x[8]};
			tilemap_pkg::reg_scroll_y: return s.scroll_y;
			default: return 8'd0;
		endcase
	endfunction

	// Address decode, anything from reg_base up is register space
	assign access = wb_req.cyc && wb_req.stb;
	assign is_ram = wb_req.adr < tilemap_pkg::reg_base;
	assign reg_hit = wb_req.adr[tilemap_pkg::ram_addr_w-1:3] ==
		tilemap_pkg::reg_base[tilemap_pkg::ram_addr_w-1:3];
	assign reg_off = wb_req.adr[2:0];

	// No new cycle while ack is out, stb is still high then
	assign ram_start = access && is_ram && !ram_busy && !ack_q;
	assign reg_start = access && !is_ram && !ack_q;
	assign reg_write = reg_start && reg_hit && wb_req.we;

	always_comb begin
		reg_rdata = 8'd0;
		if (reg_hit)
			reg_rdata = read_scroll(reg_off[2] ? scroll_b : scroll_a, reg_off[1:0]);
	end

	// Tile RAM request stays up from stb until the arbiter finishes it
	always_comb begin
		cpu_req.en = ram_busy || ram_start;
		cpu_req.we = wb_req.we;
		cpu_req.addr = wb_req.adr[tilemap_pkg::tile_addr_w-1:0];
		cpu_req.wdata = wb_req.dat_w;
	end

	always_ff @(posedge CLK_6M or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			ram_busy <= 1'b0;
			scroll_a <= '0;
			scroll_b <= '0;
		end else begin
			ack_q <= reg_start || cpu_done;
			if (ram_start)
				ram_busy <= 1'b1;
			else if (cpu_done)
				ram_busy <= 1'b0;
			if (reg_write && !reg_off[2])
				scroll_a <= write_scroll(scroll_a, reg_off[1:0], wb_req.dat_w);
			if (reg_write && reg_off[2])
				scroll_b <= write_scroll(scroll_b, reg_off[1:0], wb_req.dat_w);
		end
	end

	// Read data for the ack cycle
	always_ff @(posedge CLK_6M) begin
		if (reg_start)
			rdata_q <= reg_rdata;
		else if (cpu_done)
			rdata_q <= cpu_rdata;
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat_r = rdata_q;

endmodule

// File: source/beam_timer.sv
`timescale 1ns/1ps

module beam_timer (
	input logic CLK_6M,
	input logic rst_n,
	input logic hsync_n,
	input logic vsync_n,
	output tilemap_pkg::beam_t beam,
	output logic tile_valid
);

	logic [2:0] slot_q;
	logic [5:0] group_q;
	logic [7:0] line_q;
	logic [7:0] line_next;
	logic hsync_q;
	logic hs_rise;

	assign hs_rise = hsync_n && !hsync_q;

	// Line value for the whole active line, already counted in its first cycle
	assign line_next = !vsync_n ? 8'd0 : (hs_rise ? line_q + 8'd1 : line_q);

	always_ff @(posedge CLK_6M or negedge rst_n) begin
		if (!rst_n) begin
			slot_q <= 3'd0;
			group_q <= 6'd0;
			line_q <= 8'd0;
			hsync_q <= 1'b1;
			tile_valid <= 1'b0;
		end else begin
			hsync_q <= hsync_n;
			line_q <= line_next;
			if (!hsync_n) begin
				slot_q <= 3'd0;
				group_q <= 6'd0;
			end else begin
				slot_q <= slot_q + 3'd1;
				if (&slot_q)
					group_q <= group_q + 6'd1;
			end
			// Strobe lands on the cycle where slot becomes slot_valid
			tile_valid <= hsync_n && vsync_n && (slot_q == tilemap_pkg::slot_valid - 3'd1);
		end
	end

	always_comb begin
		beam.in_sync = !hsync_n;
		beam.slot = slot_q;
		beam.group = group_q;
		beam.line = line_next;
	end

endmodule

// File: source/tilemap_layer.sv
`timescale 1ns/1ps

module tilemap_layer #(
	parameter int layer_id = 0
) (
	input logic CLK_6M,
	input logic rst_n,
	input tilemap_pkg::beam_t beam,
	input tilemap_pkg::scroll_t scroll,
	input logic [7:0] ram_rdata,
	output logic [tilemap_pkg::tile_addr_w-1:0] entry_addr,
	output tilemap_pkg::tile_fetch_t fetch
);

	localparam logic [tilemap_pkg::tile_addr_w-1:0] base = (layer_id == 0) ?
		tilemap_pkg::layer_a_base[tilemap_pkg::tile_addr_w-1:0] :
		tilemap_pkg::layer_b_base[tilemap_pkg::tile_addr_w-1:0];
	localparam logic [2:0] attr_slot = (layer_id == 0) ?
		tilemap_pkg::slot_a_attr : tilemap_pkg::slot_b_attr;
	localparam logic [2:0] code_slot = (layer_id == 0) ?
		tilemap_pkg::slot_a_code : tilemap_pkg::slot_b_code;
	localparam logic [2:0] fetch_slot = tilemap_pkg::slot_valid - 3'd1;
	localparam int col_w = $clog2(tilemap_pkg::map_cols);
	localparam int row_w = $clog2(tilemap_pkg::map_rows);

	logic [8:0] pix_x;
	logic [7:0] pix_y;
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic cap_attr;
	logic cap_code;
	logic do_fetch;
	tilemap_pkg::tile_entry_u entry_q;
	tilemap_pkg::tile_entry_u entry_now;

	//////////////////////////////////////////////////
	// Entry address for the next pixel group
	//////////////////////////////////////////////////

	assign pix_x = {beam.group + 6'd1, 3'b000} + scroll.scroll_x;
	assign pix_y = beam.line + scroll.scroll_y;
	assign col = pix_x[8:3];
	assign row = pix_y[7:3];

	// Two bytes per entry, attr first
	assign entry_addr = base + {row, col, 1'b0};

	// RAM data shows up one slot after its address
	assign cap_attr = !beam.in_sync && (beam.slot == attr_slot + 3'd1);
	assign cap_code = !beam.in_sync && (beam.slot == code_slot + 3'd1);
	assign do_fetch = !beam.in_sync && (beam.slot == fetch_slot);

	always_ff @(posedge CLK_6M) begin
		if (cap_attr)
			entry_q.bytes.attr <= ram_rdata;
		if (cap_code)
			entry_q.bytes.code <= ram_rdata;
	end

	// Layer B's code byte arrives on the same edge as the fetch update
	always_comb begin
		entry_now = entry_q;
		if (cap_code)
			entry_now.bytes.code = ram_rdata;
	end

	//////////////////////////////////////////////////
	// Fetch result
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge rst_n) begin
		if (!rst_n) begin
			fetch <= '0;
		end else if (do_fetch) begin
			fetch.gfx_addr <= {entry_now.fields.code_hi, entry_now.fields.code_lo, pix_y[2:0]};
			fetch.color <= entry_now.fields.color;
			fetch.fine_x <= scroll.scroll_x[2:0];
		end
	end

endmodule

// File: source/tilemap_top.sv
`timescale 1ns/1ps

module tilemap_top (
	input logic CLK_6M,
	input logic rst_n,
	input logic hsync_n,
	input logic vsync_n,
	input tilemap_pkg::wb_req_t wb_req,
	output tilemap_pkg::wb_rsp_t wb_rsp,
	output tilemap_pkg::tile_fetch_t tile_a,
	output tilemap_pkg::tile_fetch_t tile_b,
	output logic tile_valid
);

	tilemap_pkg::beam_t beam;
	tilemap_pkg::ram_req_t cpu_req;
	tilemap_pkg::scroll_t scroll_a;
	tilemap_pkg::scroll_t scroll_b;
	logic cpu_done;
	logic [7:0] cpu_rdata;
	logic [7:0] ram_rdata;
	logic [tilemap_pkg::tile_addr_w-1:0] addr_a;
	logic [tilemap_pkg::tile_addr_w-1:0] addr_b;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	wb_cpu_port u_cpu_port (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.cpu_done(cpu_done),
		.cpu_rdata(cpu_rdata),
		.wb_rsp(wb_rsp),
		.cpu_req(cpu_req),
		.scroll_a(scroll_a),
		.scroll_b(scroll_b)
	);

	beam_timer u_beam_timer (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.beam(beam),
		.tile_valid(tile_valid)
	);

	// Shared tile RAM and its slot schedule
	tile_ram_arbiter u_arbiter (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.beam(beam),
		.addr_a(addr_a),
		.addr_b(addr_b),
		.cpu_req(cpu_req),
		.cpu_done(cpu_done),
		.cpu_rdata(cpu_rdata),
		.ram_rdata(ram_rdata)
	);

	//////////////////////////////////////////////////
	// Layers, fetch results go straight out
	//////////////////////////////////////////////////

	tilemap_layer #(.layer_id(0)) layer_a (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.beam(beam),
		.scroll(scroll_a),
		.ram_rdata(ram_rdata),
		.entry_addr(addr_a),
		.fetch(tile_a)
	);

	tilemap_layer #(.layer_id(1)) layer_b (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.beam(beam),
		.scroll(scroll_b),
		.ram_rdata(ram_rdata),
		.entry_addr(addr_b),
		.fetch(tile_b)
	);

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic CLK_6M,
	output logic rst_n
);

	// 10 ns period
	initial begin
		CLK_6M = 1'b0;
		forever #5 CLK_6M = ~CLK_6M;
	end

	// Reset held for 8 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge CLK_6M);
		rst_n <= 1'b1;
	end

endmodule

// File: bench/tb_tilemap.sv
`timescale 1ns/1ps

module tb_tilemap;

	logic CLK_6M;
	logic rst_n;
	logic hsync_n = 1'b0;
	logic vsync_n = 1'b0;
	tilemap_pkg::wb_req_t wb_req;
	tilemap_pkg::wb_rsp_t wb_rsp;
	tilemap_pkg::tile_fetch_t tile_a;
	tilemap_pkg::tile_fetch_t tile_b;
	logic tile_valid;

	logic [31:0] rng_state = 32'd42869;
	logic [7:0] model_ram [tilemap_pkg::tile_ram_depth];
	int model_sx [2];
	int model_sy [2];
	int h_cnt = 0;
	int v_cnt = 0;
	int m_line = 0;
	int m_k = 0;
	logic m_hs_prev = 1'b1;
	logic check_en = 1'b0;
	logic stop_reads = 1'b0;
	int strobe_count = 0;
	int sync_ops = 0;

	clock_gen u_clock_gen (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n)
	);

	tilemap_top dut (
		.CLK_6M(CLK_6M),
		.rst_n(rst_n),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.tile_a(tile_a),
		.tile_b(tile_b),
		.tile_valid(tile_valid)
	);

	//////////////////////////////////////////////////
	// Random numbers and error handling
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'(next_rand() >> 24);
	endfunction

	function automatic int rand_below(input int n);
		return int'((next_rand() >> 8) % n);
	endfunction

	task automatic stop_failed();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_fetch(input string name, input tilemap_pkg::tile_fetch_t got,
			input tilemap_pkg::tile_fetch_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h (gfx_addr %h/%h color %h/%h fine_x %h/%h)",
				name, got, exp, got.gfx_addr, exp.gfx_addr, got.color, exp.color,
				got.fine_x, exp.fine_x);
			stop_failed();
		end
	endtask

	task automatic check_read(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			stop_failed();
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Tile rule for one layer and one pixel group
	function automatic tilemap_pkg::tile_fetch_t expected_fetch(input int layer,
			input int pix_group, input int line_no);
		tilemap_pkg::tile_fetch_t f;
		int x;
		int y;
		int addr;
		int tile_no;
		logic [7:0] attr;
		logic [7:0] code;
		x = (pix_group * 8 + model_sx[layer]) % 512;
		y = (line_no + model_sy[layer]) % 256;
		addr = (layer == 0) ? int'(tilemap_pkg::layer_a_base) : int'(tilemap_pkg::layer_b_base);
		addr = addr + ((y / 8) * tilemap_pkg::map_cols + x / 8) * 2;
		attr = model_ram[addr];
		code = model_ram[addr + 1];
		tile_no = int'({attr[2:0], code});
		f.gfx_addr = 14'(tile_no * 8 + y % 8);
		f.color = attr[7:3];
		f.fine_x = 3'(model_sx[layer] % 8);
		return f;
	endfunction

	function automatic logic [7:0] expected_reg(input int off);
		int l;
		l = off / 4;
		case (off % 4)
			0: return 8'(model_sx[l] & 255);
			1: return 8'(model_sx[l] >> 8);
			2: return 8'(model_sy[l]);
			default: return 8'h00;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Sync generator and fetch monitor
	//////////////////////////////////////////////////

	// 56 cycles per line with 8 in hsync and 20 lines per frame with 2 in vsync
	always @(posedge CLK_6M) begin : sync_gen
		int h_nxt;
		int v_nxt;
		if (!rst_n) begin
			h_nxt = 0;
			v_nxt = 0;
		end else begin
			h_nxt = (h_cnt == 55) ? 0 : h_cnt + 1;
			v_nxt = v_cnt;
			if (h_cnt == 55)
				v_nxt = (v_cnt == 19) ? 0 : v_cnt + 1;
		end
		h_cnt <= h_nxt;
		v_cnt <= v_nxt;
		hsync_n <= (h_nxt >= 8);
		vsync_n <= (v_nxt >= 2);
	end

	// Tracks line and strobe index from the sync inputs of the cycle just ended
	always @(posedge CLK_6M) begin : fetch_monitor
		tilemap_pkg::tile_fetch_t exp_a;
		tilemap_pkg::tile_fetch_t exp_b;
		if (!rst_n) begin
			m_line = 0;
			m_k = 0;
			m_hs_prev = 1'b1;
		end else begin
			if (!vsync_n)
				m_line = 0;
			else if (hsync_n && !m_hs_prev)
				m_line = (m_line + 1) % 256;
			if (hsync_n && !m_hs_prev)
				m_k = 0;
			m_hs_prev = hsync_n;
			if (tile_valid) begin
				if (!hsync_n || !vsync_n) begin
					$display("tile_valid was high during horizontal or vertical sync");
					stop_failed();
				end
				if (check_en) begin
					exp_a = expected_fetch(0, m_k + 1, m_line);
					exp_b = expected_fetch(1, m_k + 1, m_line);
					check_fetch("tile_a", tile_a, exp_a);
					check_fetch("tile_b", tile_b, exp_b);
					strobe_count <= strobe_count + 1;
				end
				m_k = m_k + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus and wait tasks
	//////////////////////////////////////////////////

	// Starts and returns on a rising edge
	task automatic wb_access(input logic we, input logic [13:0] adr, input logic [7:0] wdat,
			output logic [7:0] rdat);
		tilemap_pkg::wb_req_t req;
		int waited;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr;
		req.dat_w = wdat;
		if (!hsync_n)
			sync_ops++;
		wb_req <= req;
		waited = 0;
		do begin
			@(posedge CLK_6M);
			waited++;
			if (waited > 200) begin
				$display("No ack within 200 cycles for address %h", adr);
				stop_failed();
			end
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat_r;
		wb_req <= '0;
		@(posedge CLK_6M);
		if (wb_rsp.ack) begin
			$display("Ack stayed high for more than one cycle at address %h", adr);
			stop_failed();
		end
	endtask

	task automatic write_reg(input int off, input logic [7:0] d);
		logic [7:0] rd;
		int l;
		l = off / 4;
		wb_access(1'b1, tilemap_pkg::reg_base + 14'(off), d, rd);
		case (off % 4)
			0: model_sx[l] = (model_sx[l] & 256) | int'(d);
			1: model_sx[l] = (model_sx[l] & 255) | (int'(d[0]) << 8);
			2: model_sy[l] = int'(d);
			default: ;
		endcase
	endtask

	task automatic read_reg_check(input int off);
		logic [7:0] rd;
		wb_access(1'b0, tilemap_pkg::reg_base + 14'(off), 8'h00, rd);
		check_read($sformatf("wb_rsp.dat_r[reg %0d]", off), rd, expected_reg(off));
	endtask

	task automatic set_random_scroll();
		int i;
		for (i = 0; i < 6; i++)
			write_reg((i < 3) ? i : i + 1, rand_byte());
	endtask

	task automatic write_ram(input int addr, input logic [7:0] d);
		logic [7:0] rd;
		wb_access(1'b1, 14'(addr), d, rd);
		model_ram[addr] = d;
	endtask

	task automatic read_ram_check(input int addr);
		logic [7:0] rd;
		wb_access(1'b0, 14'(addr), 8'h00, rd);
		check_read($sformatf("wb_rsp.dat_r[%h]", addr), rd, model_ram[addr]);
	endtask

	// Returns in the first cycle of a vsync period
	task automatic wait_vsync_start();
		logic prev;
		int waited;
		prev = 1'b0;
		waited = 0;
		@(posedge CLK_6M);
		while (!(prev && !vsync_n)) begin
			prev = vsync_n;
			@(posedge CLK_6M);
			waited++;
			if (waited > 2500) begin
				$display("vsync_n did not fall within 2500 cycles");
				stop_failed();
			end
		end
	endtask

	task automatic wait_strobes(input int n);
		int target;
		int last;
		int idle;
		target = strobe_count + n;
		last = strobe_count;
		idle = 0;
		while (strobe_count < target) begin
			@(posedge CLK_6M);
			if (strobe_count != last) begin
				last = strobe_count;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > 200) begin
				$display("No tile_valid strobe within 200 cycles");
				stop_failed();
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : main
		logic [7:0] rd;
		int i;
		int n;
		wb_req <= '0;
		n = 0;
		while (!rst_n) begin
			@(posedge CLK_6M);
			n++;
			if (n > 50) begin
				$display("Reset was never released");
				stop_failed();
			end
		end
		@(posedge CLK_6M);

		// Idle outputs and cleared scroll registers
		if (wb_rsp.ack || tile_valid) begin
			$display("ack or tile_valid high right after reset");
			stop_failed();
		end
		check_fetch("tile_a", tile_a, '0);
		check_fetch("tile_b", tile_b, '0);
		for (i = 0; i < 8; i++)
			read_reg_check(i);

		// Scroll registers written during vsync
		repeat (3) begin
			wait_vsync_start();
			set_random_scroll();
			for (i = 0; i < 8; i++)
				read_reg_check(i);
			// Unused register space runs from 0x2008 to the top of the 14-bit map
			wb_access(1'b0, 14'(32'h2008 + rand_below(32'h1ff8)), 8'h00, rd);
			check_read("wb_rsp.dat_r[unused reg]", rd, 8'h00);
		end

		// Fill the whole tile RAM and then mix traffic at random points
		for (i = 0; i < tilemap_pkg::tile_ram_depth; i++)
			write_ram(i, rand_byte());
		for (n = 0; n < 600; n++) begin
			repeat (rand_below(8)) @(posedge CLK_6M);
			if (rand_below(2) == 1)
				write_ram(rand_below(tilemap_pkg::tile_ram_depth), rand_byte());
			else
				read_ram_check(rand_below(tilemap_pkg::tile_ram_depth));
		end
		for (n = 0; n < 400; n++)
			read_ram_check(rand_below(tilemap_pkg::tile_ram_depth));
		if (sync_ops == 0) begin
			$display("No tile RAM access was issued during hsync");
			stop_failed();
		end

		// Two frames of fetches with no CPU traffic
		wait_vsync_start();
		set_random_scroll();
		check_en <= 1'b1;
		wait_strobes(216);

		// Two more frames with back to back CPU reads
		wait_vsync_start();
		set_random_scroll();
		n = 0;
		fork
			begin
				wait_strobes(216);
				stop_reads = 1'b1;
			end
			begin : reader
				int a;
				while (!stop_reads) begin
					a = rand_below(tilemap_pkg::tile_ram_depth);
					read_ram_check(a);
					n++;
				end
			end
		join
		if (n == 0) begin
			$display("No CPU reads completed while fetches were checked");
			stop_failed();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: sim.f
source/tilemap_pkg.sv
source/tile_ram.sv
source/tile_ram_arbiter.sv
source/wb_cpu_port.sv
source/beam_timer.sv
source/tilemap_layer.sv
source/tilemap_top.sv
bench/clock_gen.sv
bench/tb_tilemap.sv

// File: run_sim.sh
#!/bin/sh
# Build the tilemap testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_tilemap -f sim.f -o tb_tilemap_sim

# tee keeps the log even when the simulation stops on an error
./obj_dir/tb_tilemap_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
